// File: logic/cpu_6s46_params.svh
`ifndef CPU_6S46_PARAMS_SVH
`define CPU_6S46_PARAMS_SVH

// Cycles per instruction, register operands only.
`define CPU_6S46_SHORT_STEPS 5

// Cycles per instruction when an operand is MX or MY.
`define CPU_6S46_LONG_STEPS 7

// Data space I/O window.
`define CPU_6S46_IO_BASE 8'hF0
`define CPU_6S46_IO_K0 8'hF0
`define CPU_6S46_IO_K1 8'hF1
`define CPU_6S46_IO_R4 8'hF4

`endif

// File: logic/cpu_6s46_pkg.sv
package cpu_6s46_pkg;

  typedef logic [3:0] nibble_t;

  typedef logic [7:0] ptr_t;

  typedef logic [12:0] rom_addr_t;

  typedef logic [11:0] instr_t;

  // A, B, MX, MY.
  typedef logic [1:0] sel_t;

  typedef enum logic [1:0] {
    alu_pass,
    alu_add,
    alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    step_fetch,
    step_decode,
    step_read,
    step_execute,
    step_write,
    step_next,
    step_halted
  } step_t;

endpackage

// File: logic/cpu_6s46_regs.sv
module cpu_6s46_regs (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   a_we,
  input  logic                   b_we,
  input  logic                   x_we,
  input  logic                   y_we,
  input  logic                   flags_we,
  input  cpu_6s46_pkg::nibble_t  wdata,
  input  cpu_6s46_pkg::ptr_t     ptr_wdata,
  input  logic                   carry_in,
  input  logic                   zero_in,
  input  logic                   pc_inc,
  input  logic                   pc_load,
  input  cpu_6s46_pkg::ptr_t     pc_target,
  output cpu_6s46_pkg::nibble_t  a,
  output cpu_6s46_pkg::nibble_t  b,
  output cpu_6s46_pkg::ptr_t     x,
  output cpu_6s46_pkg::ptr_t     y,
  output cpu_6s46_pkg::rom_addr_t pc,
  output logic                   carry,
  output logic                   zero
);

  cpu_6s46_pkg::ptr_t sp;

  always_ff @(posedge clk) begin
    if (reset_n) begin
      a     <= '0;
      b     <= '0;
      x     <= '0;
      y     <= '0;
      sp    <= '0;
      pc    <= '0;
      carry <= 1'b0;
      zero  <= 1'b0;
    end else begin
      if (a_we) begin
        a <= wdata;
      end
      if (b_we) begin
        b <= wdata;
      end
      if (x_we) begin
        x <= ptr_wdata;
      end
      if (y_we) begin
        y <= ptr_wdata;
      end
      if (flags_we) begin
        carry <= carry_in;
        zero  <= zero_in;
      end
      if (pc_load) begin
        pc <= {pc[12:8], pc_target}; // Stays on the current page.
      end else if (pc_inc) begin
        pc <= pc + 13'd1;
      end
      sp <= sp; // No stack ops in this subset.
    end
  end

endmodule

// File: logic/cpu_6s46_alu.sv
module cpu_6s46_alu (
  input  cpu_6s46_pkg::alu_op_t op,
  input  cpu_6s46_pkg::nibble_t lhs,
  input  cpu_6s46_pkg::nibble_t rhs,
  output cpu_6s46_pkg::nibble_t result,
  output logic                  carry_out,
  output logic                  zero_out
);

  logic [4:0] sum;

  assign sum = {1'b0, lhs} + {1'b0, rhs};

  always_comb begin
    case (op)
      cpu_6s46_pkg::alu_add: begin
        result    = sum[3:0];
        carry_out = sum[4];
      end
      cpu_6s46_pkg::alu_and: begin
        result    = lhs & rhs;
        carry_out = 1'b0;
      end
      default: begin
        result    = rhs; // Plain load.
        carry_out = 1'b0;
      end
    endcase
  end

  assign zero_out = (result == 4'd0);

endmodule

// File: logic/cpu_6s46_microcode.sv
`include "cpu_6s46_params.svh"

module cpu_6s46_microcode (
  input  logic                  clk,
  input  logic                  reset_n,
  input  cpu_6s46_pkg::instr_t  rom_data,
  input  logic                  carry,
  input  logic                  zero,
  output cpu_6s46_pkg::sel_t    operand_r,
  output cpu_6s46_pkg::sel_t    operand_q,
  output logic                  use_imm,
  output cpu_6s46_pkg::alu_op_t alu_op,
  output logic                  a_we,
  output logic                  b_we,
  output logic                  flags_we,
  output logic                  pc_inc,
  output logic                  pc_load,
  output logic                  ptr_load_x,
  output logic                  ptr_load_y,
  output logic                  mem_sel_y,
  output logic                  mem_we,
  output logic                  last_step,
  output logic                  halt
);

  localparam logic [2:0] short_last = 3'(`CPU_6S46_SHORT_STEPS - 1);
  localparam logic [2:0] long_last = 3'(`CPU_6S46_LONG_STEPS - 1);

  cpu_6s46_pkg::step_t  step;
  cpu_6s46_pkg::instr_t instr;
  logic [2:0]           cyc;
  logic op_ld_imm, op_add_imm, op_and_imm, op_ld_reg, op_add_reg;
  logic op_ld_x, op_ld_y, op_jp, op_jc, op_jnz, op_halt;
  logic reg_form, alu_instr, mem_r, mem_q, is_mem, in_exec, taken;

  assign op_ld_imm  = (instr[11:6] == 6'b1110_00);
  assign op_add_imm = (instr[11:6] == 6'b1100_00);
  assign op_and_imm = (instr[11:6] == 6'b1100_10);
  assign op_ld_reg  = (instr[11:4] == 8'hEC);
  assign op_add_reg = (instr[11:4] == 8'hA8);
  assign op_ld_x    = (instr[11:8] == 4'hB);
  assign op_ld_y    = (instr[11:8] == 4'h8);
  assign op_jp      = (instr[11:8] == 4'h0);
  assign op_jc      = (instr[11:8] == 4'h2);
  assign op_jnz     = (instr[11:8] == 4'h7);
  assign op_halt    = (instr == 12'hFF8);

  assign reg_form  = op_ld_reg | op_add_reg;
  assign use_imm   = op_ld_imm | op_add_imm | op_and_imm;
  assign alu_instr = use_imm | reg_form;
  assign operand_r = reg_form ? instr[3:2] : instr[5:4];
  assign operand_q = instr[1:0];
  assign mem_r     = alu_instr & operand_r[1];
  assign mem_q     = reg_form & operand_q[1];
  assign is_mem    = mem_r | mem_q; // Adds the read and write steps.

  always_comb begin
    if (op_add_imm | op_add_reg) begin
      alu_op = cpu_6s46_pkg::alu_add;
    end else if (op_and_imm) begin
      alu_op = cpu_6s46_pkg::alu_and;
    end else begin
      alu_op = cpu_6s46_pkg::alu_pass;
    end
  end

  assign in_exec    = (step == cpu_6s46_pkg::step_execute);
  assign a_we       = in_exec && alu_instr && (operand_r == 2'd0);
  assign b_we       = in_exec && alu_instr && (operand_r == 2'd1);
  assign flags_we   = in_exec && (op_add_imm || op_add_reg || op_and_imm);
  assign ptr_load_x = in_exec && op_ld_x;
  assign ptr_load_y = in_exec && op_ld_y;
  // Source pointer while reading, destination pointer afterwards.
  assign mem_sel_y  = (step == cpu_6s46_pkg::step_read) ? operand_q[0] : operand_r[0];
  assign mem_we     = (step == cpu_6s46_pkg::step_write) && mem_r;
  assign last_step  = (step == cpu_6s46_pkg::step_next) &&
                      (cyc == (is_mem ? long_last : short_last));
  assign taken      = op_jp | (op_jc & carry) | (op_jnz & ~zero);
  assign pc_load    = last_step & taken;
  assign pc_inc     = last_step & ~taken;
  assign halt       = (step == cpu_6s46_pkg::step_halted);

  always_ff @(posedge clk) begin
    if (step == cpu_6s46_pkg::step_fetch) begin
      instr <= rom_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_n) begin
      step <= cpu_6s46_pkg::step_fetch;
      cyc  <= 3'd0;
    end else begin
      if (step != cpu_6s46_pkg::step_halted) begin
        cyc <= last_step ? 3'd0 : cyc + 3'd1;
      end
      case (step)
        cpu_6s46_pkg::step_fetch: step <= cpu_6s46_pkg::step_decode;
        cpu_6s46_pkg::step_decode: begin
          if (op_halt) begin
            step <= cpu_6s46_pkg::step_halted; // PC keeps the HALT address.
          end else if (is_mem) begin
            step <= cpu_6s46_pkg::step_read;
          end else begin
            step <= cpu_6s46_pkg::step_execute;
          end
        end
        cpu_6s46_pkg::step_read: step <= cpu_6s46_pkg::step_execute;
        cpu_6s46_pkg::step_execute: begin
          step <= is_mem ? cpu_6s46_pkg::step_write : cpu_6s46_pkg::step_next;
        end
        cpu_6s46_pkg::step_write: step <= cpu_6s46_pkg::step_next;
        cpu_6s46_pkg::step_next: begin
          if (last_step) begin
            step <= cpu_6s46_pkg::step_fetch;
          end
        end
        default: step <= cpu_6s46_pkg::step_halted;
      endcase
    end
  end

endmodule

// File: logic/cpu_6s46_core.sv
module cpu_6s46_core (
  input  logic                    clk,
  input  logic                    reset_n,
  output cpu_6s46_pkg::rom_addr_t rom_addr,
  input  cpu_6s46_pkg::instr_t    rom_data,
  output cpu_6s46_pkg::ptr_t      mem_addr,
  output cpu_6s46_pkg::nibble_t   mem_wdata,
  output logic                    mem_we,
  input  cpu_6s46_pkg::nibble_t   mem_rdata,
  output logic                    halt
);

  cpu_6s46_pkg::nibble_t a, b, r_val, q_val, alu_result, mem_q, res_q;
  cpu_6s46_pkg::ptr_t    x, y;
  cpu_6s46_pkg::sel_t    operand_r, operand_q;
  cpu_6s46_pkg::alu_op_t alu_op;
  logic carry, zero, alu_carry, alu_zero, use_imm;
  logic a_we, b_we, flags_we, pc_inc, pc_load, ptr_load_x, ptr_load_y, mem_sel_y, last_step;

  always_comb begin
    case (operand_r)
      2'd0:    r_val = a;
      2'd1:    r_val = b;
      default: r_val = mem_rdata; // Destination pointer is on the bus.
    endcase
  end

  always_comb begin
    if (use_imm) begin
      q_val = rom_data[3:0];
    end else begin
      case (operand_q)
        2'd0:    q_val = a;
        2'd1:    q_val = b;
        default: q_val = mem_q;
      endcase
    end
  end

  assign mem_addr  = mem_sel_y ? y : x;
  assign mem_wdata = res_q;

  // Read step feeds execute, execute feeds write.
  always_ff @(posedge clk) begin
    mem_q <= mem_rdata;
    res_q <= alu_result;
  end

  cpu_6s46_regs regs (
    .clk(clk), .reset_n(reset_n),
    .a_we(a_we), .b_we(b_we), .x_we(ptr_load_x), .y_we(ptr_load_y), .flags_we(flags_we),
    .wdata(alu_result), .ptr_wdata(rom_data[7:0]),
    .carry_in(alu_carry), .zero_in(alu_zero),
    .pc_inc(pc_inc), .pc_load(pc_load), .pc_target(rom_data[7:0]),
    .a(a), .b(b), .x(x), .y(y), .pc(rom_addr), .carry(carry), .zero(zero)
  );

  cpu_6s46_alu alu (
    .op(alu_op), .lhs(r_val), .rhs(q_val),
    .result(alu_result), .carry_out(alu_carry), .zero_out(alu_zero)
  );

  cpu_6s46_microcode microcode (
    .clk(clk), .reset_n(reset_n), .rom_data(rom_data), .carry(carry), .zero(zero),
    .operand_r(operand_r), .operand_q(operand_q), .use_imm(use_imm), .alu_op(alu_op),
    .a_we(a_we), .b_we(b_we), .flags_we(flags_we), .pc_inc(pc_inc), .pc_load(pc_load),
    .ptr_load_x(ptr_load_x), .ptr_load_y(ptr_load_y), .mem_sel_y(mem_sel_y),
    .mem_we(mem_we), .last_step(last_step), .halt(halt)
  );

endmodule

// File: logic/cpu_6s46.sv
`include "cpu_6s46_params.svh"

module cpu_6s46 (
  input  logic                    clk,
  input  logic                    reset_n,
  output cpu_6s46_pkg::rom_addr_t rom_addr,
  input  cpu_6s46_pkg::instr_t    rom_data,
  input  cpu_6s46_pkg::nibble_t   input_k0,
  input  cpu_6s46_pkg::nibble_t   input_k1,
  output cpu_6s46_pkg::nibble_t   out_r4,
  output logic                    halt
);

  cpu_6s46_pkg::ptr_t    mem_addr;
  cpu_6s46_pkg::nibble_t mem_wdata, mem_rdata;
  logic                  mem_we, is_io;

  cpu_6s46_pkg::nibble_t ram [0:`CPU_6S46_IO_BASE - 1];

  assign is_io = (mem_addr >= `CPU_6S46_IO_BASE);

  always_comb begin
    if (!is_io) begin
      mem_rdata = ram[mem_addr];
    end else begin
      case (mem_addr)
        `CPU_6S46_IO_K0: mem_rdata = input_k0;
        `CPU_6S46_IO_K1: mem_rdata = input_k1;
        `CPU_6S46_IO_R4: mem_rdata = out_r4;
        default:         mem_rdata = 4'd0; // Unmapped I/O.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mem_we && !is_io) begin
      ram[mem_addr] <= mem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_n) begin
      out_r4 <= 4'd0;
    end else if (mem_we && (mem_addr == `CPU_6S46_IO_R4)) begin
      out_r4 <= mem_wdata;
    end
  end

  cpu_6s46_core core (
    .clk(clk),
    .reset_n(reset_n),
    .rom_addr(rom_addr),
    .rom_data(rom_data),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_we(mem_we),
    .mem_rdata(mem_rdata),
    .halt(halt)
  );

endmodule

// File: test/cpu_6s46_sva.sv
module cpu_6s46_sva (
  input logic                    clk,
  input logic                    reset_n,
  input logic                    mem_we,
  input logic                    halt,
  input logic                    last_step,
  input cpu_6s46_pkg::rom_addr_t rom_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  // No stores once the core has stopped.
  no_write_when_halted: assert property (@(posedge clk) disable iff (reset_n)
    !(mem_we && halt)) else $error("mem_we high while halted");

  pc_moves_at_boundary: assert property (@(posedge clk) disable iff (reset_n)
    (rom_addr != $past(rom_addr)) |-> $past(last_step))
    else $error("rom_addr changed inside an instruction");

  halt_is_sticky: assert property (@(posedge clk) disable iff (reset_n)
    halt |=> halt) else $error("halt dropped without reset");

endmodule

bind cpu_6s46_core cpu_6s46_sva i_sva (
  .clk(clk),
  .reset_n(reset_n),
  .mem_we(mem_we),
  .halt(halt),
  .last_step(last_step),
  .rom_addr(rom_addr)
);

// File: test/cpu_6s46_tb.sv
`include "cpu_6s46_params.svh"

module cpu_6s46_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int total_words = 53;
  localparam int num_rows = 7;
  localparam int cycle_limit = total_words * `CPU_6S46_LONG_STEPS + 200;

  typedef struct {
    int                      start;
    cpu_6s46_pkg::nibble_t   k0;
    cpu_6s46_pkg::nibble_t   k1;
    cpu_6s46_pkg::nibble_t   exp_out;
    cpu_6s46_pkg::rom_addr_t exp_halt;
  } row_t;

  // Programs back to back, each one runs from address 0.
  localparam cpu_6s46_pkg::instr_t program_words [0:total_words-1] = '{
    12'hE07, 12'hC05, 12'hBF4, 12'hEC8, 12'hFF8, // Sum to out_r4.
    12'hE09, 12'hC08, 12'hBF4, 12'h206, 12'hEC8, 12'hFF8,
    12'hE06, 12'hEC8, 12'hFF8, // Carry taken.
    12'hE09, 12'hC03, 12'hBF4, 12'h206, 12'hEC8, 12'hFF8,
    12'hE06, 12'hEC8, 12'hFF8, // Carry clear, falls through.
    12'hE05, 12'hC8A, 12'h707, 12'hBF4, 12'hE19, 12'hEC9, 12'hFF8, 12'hFF8, // Zero.
    12'hE03, 12'hE10, 12'hC11, 12'hC0F, 12'h702, 12'hBF4, 12'hEC9, 12'hFF8, // Loop.
    12'hB10, 12'hE0D, 12'hEC8, 12'h8F4, 12'hE00, 12'hECE, 12'hFF8, // RAM copy.
    12'hBF0, 12'h8F1, 12'hEC2, 12'hA83, 12'hBF4, 12'hEC8, 12'hFF8 // Inputs.
  };

  logic                    clk;
  logic                    reset_n;
  cpu_6s46_pkg::rom_addr_t rom_addr;
  cpu_6s46_pkg::instr_t    rom_data;
  cpu_6s46_pkg::nibble_t   input_k0;
  cpu_6s46_pkg::nibble_t   input_k1;
  cpu_6s46_pkg::nibble_t   out_r4;
  logic                    halt;
  int                      base;
  int                      cycles;
  integer                  seed;
  logic [31:0]             draw;
  row_t                    rows [num_rows];

  cpu_6s46 i_dut (
    .clk(clk),
    .reset_n(reset_n),
    .rom_addr(rom_addr),
    .rom_data(rom_data),
    .input_k0(input_k0),
    .input_k1(input_k1),
    .out_r4(out_r4),
    .halt(halt)
  );

  assign rom_data = program_words[base + int'(rom_addr)]; // Combinational ROM.

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the core did not reach HALT within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped");
    end
  end

  task automatic check_nibble(input string name, input cpu_6s46_pkg::nibble_t got,
                              input cpu_6s46_pkg::nibble_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_addr(input string name, input cpu_6s46_pkg::rom_addr_t got,
                            input cpu_6s46_pkg::rom_addr_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset_n  = 1'b1;
    input_k0 = 4'h0;
    input_k1 = 4'h0;
    base     = 0;
    cycles   = 0;
    seed     = 32'h859b_d2ec;
    rows[0] = '{0, 4'h0, 4'h0, 4'hC, 13'd4}; // 7 + 5.
    rows[1] = '{5, 4'h0, 4'h0, 4'h6, 13'd8}; // 9 + 8 carries.
    rows[2] = '{14, 4'h0, 4'h0, 4'hC, 13'd5}; // 9 + 3, no carry.
    rows[3] = '{23, 4'h0, 4'h0, 4'h9, 13'd6}; // 5 & A is zero.
    rows[4] = '{31, 4'h0, 4'h0, 4'h3, 13'd7}; // Three passes.
    rows[5] = '{39, 4'h0, 4'h0, 4'hD, 13'd6};
    draw = $random(seed);
    rows[6] = '{46, draw[3:0], draw[7:4], 4'(draw[3:0] + draw[7:4]), 13'd6};

    for (int i = 0; i < num_rows; i++) begin
      @(negedge clk);
      reset_n  = 1'b1;
      base     = rows[i].start;
      input_k0 = rows[i].k0;
      input_k1 = rows[i].k1;
      repeat (2) @(negedge clk);
      check_nibble("out_r4", out_r4, 4'h0); // Cleared by reset.
      check_flag("halt", halt, 1'b0);
      reset_n = 1'b0;
      while (!halt) begin
        @(negedge clk);
      end
      check_nibble("out_r4", out_r4, rows[i].exp_out);
      check_addr("rom_addr", rom_addr, rows[i].exp_halt);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: cpu_6s46.f
+incdir+logic
logic/cpu_6s46_pkg.sv
logic/cpu_6s46_regs.sv
logic/cpu_6s46_alu.sv
logic/cpu_6s46_microcode.sv
logic/cpu_6s46_core.sv
logic/cpu_6s46.sv
test/cpu_6s46_sva.sv
test/cpu_6s46_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpu_6s46.f \
  --top-module cpu_6s46_tb --Mdir obj_dir -o sim_cpu_6s46

./obj_dir/sim_cpu_6s46 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported a failure."
  exit 1
fi
echo "Simulation finished without failures."
